/* icache_settings.svh */
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

// Byte address
`define ICACHE_ADDR_WIDTH 32
// Four 32-bit words per line
`define ICACHE_LINE_WIDTH 128
`define ICACHE_NWAY 2
`define ICACHE_NSET 64
// Victim selection
`define ICACHE_LFSR_WIDTH 16

// Derived address fields
`define ICACHE_OFFSET_WIDTH ($clog2(`ICACHE_LINE_WIDTH / 8))
`define ICACHE_INDEX_WIDTH ($clog2(`ICACHE_NSET))
`define ICACHE_TAG_WIDTH (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH)

`endif

/* icache_pkg.sv */
`include "icache_settings.svh"

package icache_pkg;

    //////////////////////////////////////////////////
    // Address word
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`ICACHE_TAG_WIDTH-1:0] tag;
        logic [`ICACHE_INDEX_WIDTH-1:0] index;
        logic [`ICACHE_OFFSET_WIDTH-1:0] offset;
    } addr_fields_t;

    // Raw word for the memory side and low-bit way select
    typedef union packed {
        logic [`ICACHE_ADDR_WIDTH-1:0] raw;
        addr_fields_t f;
    } addr_u;

    //////////////////////////////////////////////////
    // Storage and request types
    //////////////////////////////////////////////////

    typedef struct packed {
        logic valid;
        logic [`ICACHE_TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        addr_u addr;
        logic uncached;
    } rd_req_t;

    // One command per way
    typedef struct packed {
        logic en;
        logic we;
        logic [`ICACHE_INDEX_WIDTH-1:0] index;
        tag_entry_t entry;
        logic [`ICACHE_LINE_WIDTH-1:0] line;
    } way_cmd_t;

    typedef struct packed {
        tag_entry_t entry;
        logic [`ICACHE_LINE_WIDTH-1:0] line;
    } way_rd_t;

    // Tag clear request from the maintenance block
    typedef struct packed {
        logic [`ICACHE_NWAY-1:0] way_mask;
        logic [`ICACHE_INDEX_WIDTH-1:0] index;
    } tag_clear_t;

endpackage

/* icache_way_store.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_way_store (
    input logic clk,
    input icache_pkg::way_cmd_t cmd_i,
    output icache_pkg::way_rd_t rd_o
);

    localparam int NSET = `ICACHE_NSET;
    localparam int LINE_W = `ICACHE_LINE_WIDTH;

    // Tag and data arrays
    icache_pkg::tag_entry_t tag_mem [NSET];
    logic [LINE_W-1:0] line_mem [NSET];

    //////////////////////////////////////////////////
    // Single port access
    //////////////////////////////////////////////////

    // Write has priority over read in the same command
    always_ff @(posedge clk) begin
        if (cmd_i.en) begin
            if (cmd_i.we) begin
                tag_mem[cmd_i.index] <= cmd_i.entry;
                line_mem[cmd_i.index] <= cmd_i.line;
            end else begin
                rd_o.entry <= tag_mem[cmd_i.index];
                rd_o.line <= line_mem[cmd_i.index];
            end
        end
    end

endmodule

/* icache_maint.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_maint (
    input logic clk,
    input logic rst,

    input logic inv_i,

    input logic cacop_valid_i,
    input logic [1:0] cacop_mode_i,
    input icache_pkg::addr_u cacop_addr_i,
    output logic cacop_ready_o,

    output logic clr_valid_o,
    output icache_pkg::tag_clear_t clr_o,
    input logic clr_ready_i,

    output logic maint_busy_o
);

    localparam int NWAY = `ICACHE_NWAY;
    localparam int NSET = `ICACHE_NSET;
    localparam int IDX_W = `ICACHE_INDEX_WIDTH;
    localparam int WAY_W = (NWAY > 1) ? $clog2(NWAY) : 1;

    logic sweep_q;
    logic [IDX_W-1:0] sweep_idx_q;
    logic sweep_last;

    logic cacop_all;
    logic [WAY_W-1:0] cacop_way;
    logic [NWAY-1:0] cacop_mask;

    //////////////////////////////////////////////////
    // Invalidate sweep
    //////////////////////////////////////////////////

    assign sweep_last = sweep_idx_q == IDX_W'(NSET - 1);

    // Reset starts a sweep on its own
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_q <= 1'b1;
            sweep_idx_q <= '0;
        end else if (!sweep_q) begin
            if (inv_i) begin
                sweep_q <= 1'b1;
                sweep_idx_q <= '0;
            end
        end else if (clr_ready_i) begin
            sweep_idx_q <= sweep_idx_q + 1'b1;
            if (sweep_last) begin
                sweep_q <= 1'b0;
            end
        end
    end

    assign maint_busy_o = sweep_q;

    //////////////////////////////////////////////////
    // Index maintenance
    //////////////////////////////////////////////////

    // Mode 2 hits all ways at the index
    assign cacop_all = cacop_mode_i == 2'd2;
    assign cacop_way = cacop_addr_i.raw[WAY_W-1:0];

    always_comb begin
        cacop_mask = '0;
        for (int w = 0; w < NWAY; w++) begin
            if (cacop_all || cacop_way == WAY_W'(w)) begin
                cacop_mask[w] = 1'b1;
            end
        end
    end

    // Sweep wins over a maintenance request
    always_comb begin
        if (sweep_q) begin
            clr_o.way_mask = '1;
            clr_o.index = sweep_idx_q;
        end else begin
            clr_o.way_mask = cacop_mask;
            clr_o.index = cacop_addr_i.f.index;
        end
    end

    assign clr_valid_o = sweep_q || cacop_valid_i;
    assign cacop_ready_o = !sweep_q && clr_ready_i;

endmodule

/* icache_ctrl.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl (
    input logic clk,
    input logic rst,

    // Read port
    input logic rd_valid_i,
    input icache_pkg::rd_req_t rd_req_i,
    output logic rd_ready_o,
    output logic rsp_valid_o,
    output logic [`ICACHE_LINE_WIDTH-1:0] rsp_data_o,

    // Refill port
    output logic mem_req_valid_o,
    output icache_pkg::addr_u mem_req_addr_o,
    input logic mem_req_ready_i,
    input logic mem_rsp_valid_i,
    input logic [`ICACHE_LINE_WIDTH-1:0] mem_rsp_data_i,

    // Tag clears
    input logic clr_valid_i,
    input icache_pkg::tag_clear_t clr_i,
    output logic clr_ready_o,
    input logic maint_busy_i,

    // Way storage
    output icache_pkg::way_cmd_t [`ICACHE_NWAY-1:0] way_cmd_o,
    input icache_pkg::way_rd_t [`ICACHE_NWAY-1:0] way_rd_i
);

    localparam int NWAY = `ICACHE_NWAY;
    localparam int LINE_W = `ICACHE_LINE_WIDTH;
    localparam int LFSR_W = `ICACHE_LFSR_WIDTH;
    localparam int WAY_W = (NWAY > 1) ? $clog2(NWAY) : 1;

    // Galois taps for x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [LFSR_W-1:0] LFSR_TAPS = LFSR_W'('hb400);
    localparam logic [LFSR_W-1:0] LFSR_SEED = LFSR_W'('hace1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e state_q;
    state_e state_d;

    logic req_valid_q;
    icache_pkg::rd_req_t req_q;

    logic [NWAY-1:0] way_hit;
    logic hit_any;
    logic hit;
    logic miss;
    logic [LINE_W-1:0] hit_line;

    logic accept;
    logic clr_grant;
    logic refill_done;
    logic refill_write;

    logic [LFSR_W-1:0] lfsr_q;
    logic [WAY_W-1:0] victim;

    //////////////////////////////////////////////////
    // Request stage
    //////////////////////////////////////////////////

    assign rd_ready_o = state_q == ST_IDLE && !miss && !maint_busy_i && !clr_valid_i;
    assign accept = rd_valid_i && rd_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
        end else if (accept) begin
            req_valid_q <= 1'b1;
        end else if (rsp_valid_o) begin
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= rd_req_i;
        end
    end

    //////////////////////////////////////////////////
    // Hit detection
    //////////////////////////////////////////////////

    always_comb begin
        hit_line = way_rd_i[0].line;
        for (int w = 0; w < NWAY; w++) begin
            way_hit[w] = way_rd_i[w].entry.valid &&
                         way_rd_i[w].entry.tag == req_q.addr.f.tag;
            if (way_hit[w]) begin
                hit_line = way_rd_i[w].line;
            end
        end
    end

    // Way outputs only match the stage right after acceptance
    assign hit_any = |way_hit;
    assign hit = req_valid_q && state_q == ST_IDLE && !req_q.uncached && hit_any;
    assign miss = req_valid_q && state_q == ST_IDLE && !hit;

    //////////////////////////////////////////////////
    // Miss FSM
    //////////////////////////////////////////////////

    assign refill_done = state_q == ST_WAIT && mem_rsp_valid_i;
    assign refill_write = refill_done && !req_q.uncached;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign mem_req_valid_o = state_q == ST_REQ;

    // Line aligned refill address
    always_comb begin
        mem_req_addr_o = req_q.addr;
        mem_req_addr_o.f.offset = '0;
    end

    assign rsp_valid_o = hit || refill_done;
    assign rsp_data_o = refill_done ? mem_rsp_data_i : hit_line;

    //////////////////////////////////////////////////
    // Victim LFSR
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= LFSR_SEED;
        end else if (lfsr_q[0]) begin
            lfsr_q <= (lfsr_q >> 1) ^ LFSR_TAPS;
        end else begin
            lfsr_q <= lfsr_q >> 1;
        end
    end

    assign victim = lfsr_q[WAY_W-1:0];

    //////////////////////////////////////////////////
    // Way port steering
    //////////////////////////////////////////////////

    assign clr_ready_o = state_q == ST_IDLE && !req_valid_q;
    assign clr_grant = clr_valid_i && clr_ready_o;

    // Reads, clears and refills never overlap
    always_comb begin
        for (int w = 0; w < NWAY; w++) begin
            way_cmd_o[w].en = 1'b0;
            way_cmd_o[w].we = 1'b0;
            way_cmd_o[w].index = rd_req_i.addr.f.index;
            way_cmd_o[w].entry = '0;
            way_cmd_o[w].line = '0;
            if (accept) begin
                way_cmd_o[w].en = 1'b1;
            end
            if (clr_grant && clr_i.way_mask[w]) begin
                way_cmd_o[w].en = 1'b1;
                way_cmd_o[w].we = 1'b1;
                way_cmd_o[w].index = clr_i.index;
            end
            if (refill_write && victim == WAY_W'(w)) begin
                way_cmd_o[w].en = 1'b1;
                way_cmd_o[w].we = 1'b1;
                way_cmd_o[w].index = req_q.addr.f.index;
                way_cmd_o[w].entry.valid = 1'b1;
                way_cmd_o[w].entry.tag = req_q.addr.f.tag;
                way_cmd_o[w].line = mem_rsp_data_i;
            end
        end
    end

endmodule

/* icache_top.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top (
    input logic clk,
    input logic rst,

    // Read port
    input logic rd_valid_i,
    input icache_pkg::rd_req_t rd_req_i,
    output logic rd_ready_o,
    output logic rsp_valid_o,
    output logic [`ICACHE_LINE_WIDTH-1:0] rsp_data_o,

    // Line refill
    output logic mem_req_valid_o,
    output icache_pkg::addr_u mem_req_addr_o,
    input logic mem_req_ready_i,
    input logic mem_rsp_valid_i,
    input logic [`ICACHE_LINE_WIDTH-1:0] mem_rsp_data_i,

    // Maintenance
    input logic inv_i,
    input logic cacop_valid_i,
    input logic [1:0] cacop_mode_i,
    input icache_pkg::addr_u cacop_addr_i,
    output logic cacop_ready_o
);

    localparam int NWAY = `ICACHE_NWAY;

    logic clr_valid;
    logic clr_ready;
    logic maint_busy;
    icache_pkg::tag_clear_t clr;

    icache_pkg::way_cmd_t [NWAY-1:0] way_cmd;
    icache_pkg::way_rd_t [NWAY-1:0] way_rd;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rd_valid_i     (rd_valid_i),
        .rd_req_i       (rd_req_i),
        .rd_ready_o     (rd_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_data_o     (rsp_data_o),
        .mem_req_valid_o(mem_req_valid_o),
        .mem_req_addr_o (mem_req_addr_o),
        .mem_req_ready_i(mem_req_ready_i),
        .mem_rsp_valid_i(mem_rsp_valid_i),
        .mem_rsp_data_i (mem_rsp_data_i),
        .clr_valid_i    (clr_valid),
        .clr_i          (clr),
        .clr_ready_o    (clr_ready),
        .maint_busy_i   (maint_busy),
        .way_cmd_o      (way_cmd),
        .way_rd_i       (way_rd)
    );

    icache_maint u_maint (
        .clk          (clk),
        .rst          (rst),
        .inv_i        (inv_i),
        .cacop_valid_i(cacop_valid_i),
        .cacop_mode_i (cacop_mode_i),
        .cacop_addr_i (cacop_addr_i),
        .cacop_ready_o(cacop_ready_o),
        .clr_valid_o  (clr_valid),
        .clr_o        (clr),
        .clr_ready_i  (clr_ready),
        .maint_busy_o (maint_busy)
    );

    // One tag and data store per way
    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_way_store u_way (
            .clk  (clk),
            .cmd_i(way_cmd[w]),
            .rd_o (way_rd[w])
        );
    end

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    // Reset held over two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

/* icache_tb_mem.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb_mem (
    input logic clk,
    input logic mem_req_valid_i,
    input icache_pkg::addr_u mem_req_addr_i,
    output logic mem_req_ready_o,
    output logic mem_rsp_valid_o,
    output logic [`ICACHE_LINE_WIDTH-1:0] mem_rsp_data_o,
    input int unsigned max_delay_i,
    output int unsigned req_count_o
);

    localparam int LINE_W = `ICACHE_LINE_WIDTH;
    localparam int NWORD = LINE_W / 32;

    // Word k of a line holds the line address XOR k
    function automatic logic [LINE_W-1:0] fill_line(input logic [31:0] line_addr);
        logic [LINE_W-1:0] line;
        for (int k = 0; k < NWORD; k++) begin
            line[32*k +: 32] = line_addr ^ 32'(k);
        end
        return line;
    endfunction

    initial begin : responder
        int unsigned delay;
        icache_pkg::addr_u addr;
        void'($urandom(32'h3f0b));
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_data_o = '0;
        req_count_o = 0;
        forever begin
            @(posedge clk);
            if (mem_req_valid_i) begin
                addr = mem_req_addr_i;
                delay = $urandom_range(max_delay_i, 0);
                repeat (delay) @(posedge clk);
                mem_req_ready_o <= 1'b1;
                // The cache holds the request up to this handshake edge
                @(posedge clk);
                mem_req_ready_o <= 1'b0;
                req_count_o <= req_count_o + 1;
                delay = $urandom_range(max_delay_i, 0);
                repeat (delay) @(posedge clk);
                mem_rsp_valid_o <= 1'b1;
                mem_rsp_data_o <= fill_line(addr.raw);
                @(posedge clk);
                mem_rsp_valid_o <= 1'b0;
            end
        end
    end

endmodule

/* icache_tb.sv */
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tb;

    localparam int LINE_W = `ICACHE_LINE_WIDTH;
    localparam int NWORD = LINE_W / 32;
    localparam int NWAY = `ICACHE_NWAY;
    localparam int TAG_W = `ICACHE_TAG_WIDTH;
    localparam int IDX_W = `ICACHE_INDEX_WIDTH;
    localparam int OFF_W = `ICACHE_OFFSET_WIDTH;
    // About 90 reads of up to 30 cycles each plus two 64-cycle sweeps
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk;
    logic rst;

    logic rd_valid;
    icache_pkg::rd_req_t rd_req;
    logic rd_ready;
    logic rsp_valid;
    logic [LINE_W-1:0] rsp_data;

    logic mem_req_valid;
    icache_pkg::addr_u mem_req_addr;
    logic mem_req_ready;
    logic mem_rsp_valid;
    logic [LINE_W-1:0] mem_rsp_data;

    logic inv;
    logic cacop_valid;
    logic [1:0] cacop_mode;
    icache_pkg::addr_u cacop_addr;
    logic cacop_ready;

    int unsigned max_delay;
    int unsigned req_count;
    int unsigned cycles = 0;
    int unsigned errors = 0;

    // Every cached address that has been filled
    logic [31:0] loaded[$];

    tb_clkgen clkgen0 (
        .clk_o(clk),
        .rst_o(rst)
    );

    icache_tb_mem mem0 (
        .clk            (clk),
        .mem_req_valid_i(mem_req_valid),
        .mem_req_addr_i (mem_req_addr),
        .mem_req_ready_o(mem_req_ready),
        .mem_rsp_valid_o(mem_rsp_valid),
        .mem_rsp_data_o (mem_rsp_data),
        .max_delay_i    (max_delay),
        .req_count_o    (req_count)
    );

    icache_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .rd_valid_i     (rd_valid),
        .rd_req_i       (rd_req),
        .rd_ready_o     (rd_ready),
        .rsp_valid_o    (rsp_valid),
        .rsp_data_o     (rsp_data),
        .mem_req_valid_o(mem_req_valid),
        .mem_req_addr_o (mem_req_addr),
        .mem_req_ready_i(mem_req_ready),
        .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rsp_data_i (mem_rsp_data),
        .inv_i          (inv),
        .cacop_valid_i  (cacop_valid),
        .cacop_mode_i   (cacop_mode),
        .cacop_addr_i   (cacop_addr),
        .cacop_ready_o  (cacop_ready)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] make_addr(input int unsigned tag, input int unsigned index,
                                              input int unsigned offset);
        icache_pkg::addr_u a;
        a.f.tag = TAG_W'(tag);
        a.f.index = IDX_W'(index);
        a.f.offset = OFF_W'(offset);
        return a.raw;
    endfunction

    // Memory pattern of the line holding addr
    function automatic logic [LINE_W-1:0] expected_line(input logic [31:0] addr);
        icache_pkg::addr_u line_addr;
        logic [LINE_W-1:0] line;
        line_addr.raw = addr;
        line_addr.f.offset = '0;
        for (int k = 0; k < NWORD; k++) begin
            line[32*k +: 32] = line_addr.raw ^ 32'(k);
        end
        return line;
    endfunction

    task automatic check_value(input logic [LINE_W-1:0] actual,
                               input logic [LINE_W-1:0] expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at time %0t: %s: got %h, expected %h",
                     $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at the first error");
        end
    endtask

    task automatic stop_with_error(input string msg);
        errors++;
        $display("Error at time %0t: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // Single read with checks on data, memory traffic and a low rd_ready_o while waiting
    task automatic read_check(input logic [31:0] addr, input logic uncached,
                              input logic expect_miss);
        icache_pkg::rd_req_t req;
        int unsigned count_before;
        logic done;
        req.addr.raw = addr;
        req.uncached = uncached;
        count_before = req_count;
        rd_valid <= 1'b1;
        rd_req <= req;
        @(posedge clk);
        while (!rd_ready) begin
            @(posedge clk);
        end
        rd_valid <= 1'b0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (rsp_valid) begin
                done = 1'b1;
                check_value(rsp_data, expected_line(addr), $sformatf("data for %h", addr));
            end else begin
                check_value(LINE_W'(rd_ready), '0, "rd_ready_o before the response");
            end
        end
        check_value(LINE_W'(req_count - count_before), LINE_W'(expect_miss),
                    $sformatf("memory requests for %h", addr));
    endtask

    task automatic stream_hits(input logic [31:0] addrs[$]);
        icache_pkg::rd_req_t req;
        logic [31:0] pending[$];
        int unsigned sent;
        int unsigned got;
        int unsigned edges;
        int unsigned count_before;
        count_before = req_count;
        sent = 0;
        got = 0;
        edges = 0;
        req.addr.raw = addrs[0];
        req.uncached = 1'b0;
        rd_valid <= 1'b1;
        rd_req <= req;
        while (got < addrs.size()) begin
            @(posedge clk);
            edges++;
            if (rsp_valid) begin
                if (pending.size() == 0) begin
                    stop_with_error("Response arrived with no read outstanding");
                end else begin
                    check_value(rsp_data, expected_line(pending.pop_front()),
                                "streamed hit data");
                    got++;
                end
            end
            if (rd_valid && rd_ready) begin
                pending.push_back(addrs[sent]);
                sent++;
                if (sent < addrs.size()) begin
                    req.addr.raw = addrs[sent];
                    rd_req <= req;
                end else begin
                    rd_valid <= 1'b0;
                end
            end
        end
        // One hit per clock
        check_value(LINE_W'(edges), LINE_W'(addrs.size() + 1), "cycles for streamed hits");
        check_value(LINE_W'(req_count - count_before), '0, "memory requests while streaming");
    endtask

    task automatic cache_op(input logic [1:0] mode, input logic [31:0] addr);
        cacop_valid <= 1'b1;
        cacop_mode <= mode;
        cacop_addr <= addr;
        @(posedge clk);
        while (!cacop_ready) begin
            @(posedge clk);
        end
        cacop_valid <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_miss_then_hit();
        logic [31:0] a;
        a = make_addr(32'h123, 20, 4);
        read_check(a, 1'b0, 1'b1);
        read_check(a, 1'b0, 1'b0);
        loaded.push_back(a);
    endtask

    task automatic test_streaming_hits();
        logic [31:0] addrs[$];
        for (int i = 0; i < 16; i++) begin
            addrs.push_back(make_addr(32'h200 + i, i, 4 * (i % 4)));
        end
        foreach (addrs[i]) begin
            read_check(addrs[i], 1'b0, 1'b1);
            loaded.push_back(addrs[i]);
        end
        stream_hits(addrs);
    endtask

    task automatic test_uncached();
        logic [31:0] a;
        a = make_addr(32'h345, 30, 8);
        read_check(a, 1'b1, 1'b1);
        read_check(a, 1'b1, 1'b1);
        // Uncached reads leave the array untouched
        read_check(a, 1'b0, 1'b1);
        read_check(a, 1'b0, 1'b0);
        loaded.push_back(a);
    endtask

    task automatic test_index_maint();
        logic [31:0] a;
        a = make_addr(32'h456, 40, 0);
        read_check(a, 1'b0, 1'b1);
        read_check(a, 1'b0, 1'b0);
        cache_op(2'd2, make_addr(0, 40, 0));
        read_check(a, 1'b0, 1'b1);
        read_check(a, 1'b0, 1'b0);
        // Way number in the low address bits
        for (int w = 0; w < NWAY; w++) begin
            cache_op(2'd0, make_addr(0, 40, w));
        end
        read_check(a, 1'b0, 1'b1);
        read_check(a, 1'b0, 1'b0);
        read_check(loaded[0], 1'b0, 1'b0);
        read_check(loaded[5], 1'b0, 1'b0);
        loaded.push_back(a);
    endtask

    task automatic test_full_invalidate();
        inv <= 1'b1;
        @(posedge clk);
        inv <= 1'b0;
        foreach (loaded[i]) begin
            read_check(loaded[i], 1'b0, 1'b1);
        end
        foreach (loaded[i]) begin
            read_check(loaded[i], 1'b0, 1'b0);
        end
    endtask

    task automatic test_refill_backpressure();
        logic [31:0] a;
        max_delay <= 12;
        for (int i = 0; i < 8; i++) begin
            a = make_addr(32'h600 + i, 48 + i, 4 * (i % 4));
            read_check(a, 1'b0, 1'b1);
            read_check(a, 1'b0, 1'b0);
            read_check(a, 1'b1, 1'b1);
        end
        max_delay <= 3;
    endtask

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout, run did not end within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    initial begin : run
        rd_valid = 1'b0;
        rd_req = '0;
        inv = 1'b0;
        cacop_valid = 1'b0;
        cacop_mode = 2'd0;
        cacop_addr = '0;
        max_delay = 3;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        // Reset sweep is running
        check_value(LINE_W'(rd_ready), '0, "rd_ready_o after reset");
        check_value(LINE_W'(rsp_valid), '0, "rsp_valid_o after reset");
        check_value(LINE_W'(mem_req_valid), '0, "mem_req_valid_o after reset");
        check_value(LINE_W'(cacop_ready), '0, "cacop_ready_o after reset");
        test_miss_then_hit();
        test_streaming_hits();
        test_uncached();
        test_index_maint();
        test_full_invalidate();
        test_refill_backpressure();
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* icache.f */
+incdir+.
icache_pkg.sv
icache_way_store.sv
icache_maint.sv
icache_ctrl.sv
icache_top.sv
tb_clkgen.sv
icache_tb_mem.sv
icache_tb.sv
